// ==== tb.f ====
hdl/fmi_pkg.sv
hdl/read_pkg.sv
hdl/read_loader.sv
hdl/extend_engine.sv
hdl/result_writer.sv
hdl/smem_top.sv
verif/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the FM-index search testbench

TOP = tb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f tb.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf obj_dir

// ==== verif/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top;
	import fmi_pkg::*;
	import read_pkg::*;

	localparam int NROWS   = 16;
	localparam int PRIMARY = 20;
	localparam int SEQ_LEN = 64;
	localparam logic [31:0] SEED = 32'h88289157;

	typedef base_e [127:0] seq_t;

	// one table row per read, expected values filled in up front
	typedef struct packed {
		logic             batch;
		logic [LEN_W-1:0] len;
		seq_t             bases;
		logic [LEN_W-1:0] exp_len;
		logic [IDX_W-1:0] exp_k;
		logic [IDX_W-1:0] exp_l;
	} row_t;

	logic                 Clk_32UI;
	logic                 rst_n_i;
	logic                 load_valid_i;
	read_line_t           load_data_i;
	logic [BATCH_W-1:0]   batch_size_i;
	wire                  load_done_o;
	wire                  dram_req_valid_o;
	logic                 dram_req_ready_i;
	occ_req_t             dram_req_o;
	logic                 dram_rsp_valid_i;
	occ_rsp_t             dram_rsp_i;
	wire                  out_valid_o;
	logic                 out_ready_i;
	result_t              out_data_o;
	wire                  out_finish_o;

	integer seed;
	integer mem_seed;
	integer rdy_seed;
	base_e ref_str [SEQ_LEN];      // index string
	logic [IDX_W-1:0] l2_tab [4];
	row_t tbl [NROWS];
	int n_rows;
	int batch_n [2];
	int first_row [2];
	int timeout_limit;
	int req_read;                  // read the engine is working on

	smem_top u_dut (
		.Clk_32UI         (Clk_32UI),
		.rst_n_i          (rst_n_i),
		.load_valid_i     (load_valid_i),
		.load_data_i      (load_data_i),
		.batch_size_i     (batch_size_i),
		.load_done_o      (load_done_o),
		.dram_req_valid_o (dram_req_valid_o),
		.dram_req_ready_i (dram_req_ready_i),
		.dram_req_o       (dram_req_o),
		.dram_rsp_valid_i (dram_rsp_valid_i),
		.dram_rsp_i       (dram_rsp_i),
		.out_valid_o      (out_valid_o),
		.out_ready_i      (out_ready_i),
		.out_data_o       (out_data_o),
		.out_finish_o     (out_finish_o)
	);

	initial begin
		Clk_32UI = 1'b0;
		forever #5 Clk_32UI = ~Clk_32UI;
	end

	// ------------------------------
	// reference model
	function automatic logic [IDX_W-1:0] adj_pos(input logic [IDX_W-1:0] p);
		return (p > PRIMARY) ? p - 1 : p;
	endfunction

	// count of base c below position q
	function automatic logic [IDX_W-1:0] occ_count(input base_e c, input logic [IDX_W-1:0] q);
		logic [IDX_W-1:0] n;
		int i;
		n = '0;
		for (i = 0; i < SEQ_LEN; i++) begin
			if (64'(i) < q && ref_str[i] == c) n++;
		end
		return n;
	endfunction

	function automatic occ_rsp_t occ_lookup(input occ_req_t req);
		occ_rsp_t rsp;
		int b;
		for (b = 0; b < 4; b++) begin
			rsp.occ_k[b] = occ_count(base_e'(b), req.addr_k);
			rsp.occ_l[b] = occ_count(base_e'(b), req.addr_l);
		end
		return rsp;
	endfunction

	// backward search from the last base, keeps the last nonempty interval
	function automatic void model_search(input logic [LEN_W-1:0] len, input seq_t s,
		output logic [LEN_W-1:0] mlen, output logic [IDX_W-1:0] k,
		output logic [IDX_W-1:0] l);
		logic [IDX_W-1:0] nk;
		logic [IDX_W-1:0] nl;
		base_e c;
		int i;
		logic done;
		k = '0;
		l = SEQ_LEN + 1;
		mlen = '0;
		done = 1'b0;
		for (i = int'(len) - 1; i >= 0 && !done; i--) begin
			c = s[i];
			nk = l2_tab[c] + occ_count(c, adj_pos(k)) + 1;
			nl = l2_tab[c] + occ_count(c, adj_pos(l)) + 1;
			if (nk >= nl) begin
				done = 1'b1;  // would be empty
			end else begin
				k = nk;
				l = nl;
				mlen++;
			end
		end
	endfunction

	// ------------------------------
	// table helpers
	function automatic base_e to_base(input byte ch);
		case (ch)
			"C": return BASE_C;
			"G": return BASE_G;
			"T": return BASE_T;
			default: return BASE_A;
		endcase
	endfunction

	function automatic seq_t pattern(input string txt);
		seq_t s;
		int j;
		for (j = 0; j < 128; j++) s[j] = BASE_A;
		for (j = 0; j < txt.len(); j++) s[j] = to_base(txt[j]);  // char j is base j
		return s;
	endfunction

	function automatic seq_t random_seq(input int len);
		seq_t s;
		logic [31:0] r;
		int j;
		for (j = 0; j < 128; j++) s[j] = BASE_A;
		for (j = 0; j < len; j++) begin
			r = $random(seed);
			s[j] = base_e'(r[1:0]);
		end
		return s;
	endfunction

	task automatic add_row(input int b, input int len, input seq_t s);
		row_t row;
		logic [LEN_W-1:0] mlen;
		logic [IDX_W-1:0] k;
		logic [IDX_W-1:0] l;
		model_search(LEN_W'(len), s, mlen, k, l);
		row.batch   = b[0];
		row.len     = LEN_W'(len);
		row.bases   = s;
		row.exp_len = mlen;
		row.exp_k   = k;
		row.exp_l   = l;
		tbl[n_rows] = row;
		if (batch_n[b] == 0) first_row[b] = n_rows;
		batch_n[b]++;
		n_rows++;
		timeout_limit += len * 8 + 10;
	endtask

	task automatic build_table();
		logic [31:0] r;
		int i;
		for (i = 0; i < SEQ_LEN; i++) begin
			r = $random(seed);
			ref_str[i] = base_e'(r[1:0]);
		end
		ref_str[0] = BASE_A;  // every base present at least once
		ref_str[1] = BASE_C;
		ref_str[2] = BASE_G;
		ref_str[3] = BASE_T;
		l2_tab[0] = '0;
		for (i = 1; i < 4; i++) l2_tab[i] = l2_tab[i-1] + occ_count(base_e'(i - 1), SEQ_LEN);

		add_row(0, 1, pattern("A"));
		add_row(0, 1, pattern("T"));
		add_row(0, 2, pattern("CG"));
		add_row(0, 3, pattern("GAT"));
		add_row(0, 40, random_seq(40));
		add_row(0, 101, random_seq(101));
		add_row(1, 2, pattern("TT"));
		add_row(1, 3, pattern("ACA"));
		add_row(1, 1, pattern("G"));
		add_row(1, 1, pattern("C"));
		add_row(1, 20, random_seq(20));
		add_row(1, 35, random_seq(35));
		add_row(1, 50, random_seq(50));
		add_row(1, 64, random_seq(64));
		add_row(1, 80, random_seq(80));
		add_row(1, 101, random_seq(101));
		timeout_limit += 200;
	endtask

	// ------------------------------
	task automatic compare_field(input string name, input logic [IDX_W-1:0] exp,
		input logic [IDX_W-1:0] act);
		assert (act === exp) else begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic load_batch(input int b);
		read_line_t line;
		logic [CL_W-1:0] hdr_line;
		idx_hdr_t hdr;
		int i;
		int n;
		req_read = 0;  // engine numbers reads from zero in every batch
		hdr.primary = PRIMARY;
		hdr.seq_len = SEQ_LEN;
		for (i = 0; i < 4; i++) hdr.l2[i] = l2_tab[i];
		hdr_line = '0;
		hdr_line[$bits(idx_hdr_t)-1:0] = hdr;

		@(negedge Clk_32UI);
		if (b > 0) compare_field("load_done_o", 1, load_done_o);  // still up from last batch
		batch_size_i = BATCH_W'(batch_n[b]);
		load_data_i  = read_line_t'(hdr_line);
		load_valid_i = 1'b1;
		n = 0;
		for (i = 0; i < n_rows; i++) begin
			if (tbl[i].batch == b[0]) begin
				@(negedge Clk_32UI);
				if (n == 0) compare_field("load_done_o", 0, load_done_o);
				line       = '0;
				line.len   = tbl[i].len;
				line.bases = tbl[i].bases;
				load_data_i = line;
				n++;
			end
		end
		@(negedge Clk_32UI);
		load_valid_i = 1'b0;  // loader is issuing now
		load_data_i  = '0;
		compare_field("load_done_o", 1, load_done_o);
		compare_field("out_finish_o", 0, out_finish_o);
	endtask

	task automatic collect_batch(input int b);
		result_t rec;
		logic [31:0] r;
		int got;
		int row;
		got = 0;
		while (got < batch_n[b]) begin
			@(negedge Clk_32UI);
			r = $random(rdy_seed);
			out_ready_i = (r[1:0] != 2'd0);
			if (out_valid_o && out_ready_i) begin
				// transfer happens at the next rising edge
				rec = out_data_o;
				row = first_row[b] + got;
				compare_field("out_finish_o", 0, out_finish_o);
				compare_field("read_num", got, rec.read_num);
				compare_field("last", (got == batch_n[b] - 1), rec.last);
				compare_field("match_len", tbl[row].exp_len, rec.match_len);
				compare_field("k", tbl[row].exp_k, rec.k);
				compare_field("l", tbl[row].exp_l, rec.l);
				got++;
			end
		end
		@(negedge Clk_32UI);
		out_ready_i = 1'b0;
		compare_field("out_finish_o", 1, out_finish_o);
		compare_field("out_valid_o", 0, out_valid_o);  // nothing left over
	endtask

	// ------------------------------
	// occurrence memory, one request at a time
	initial begin : mem_model
		occ_req_t req_q;
		logic [31:0] r;
		int wait_cnt;
		dram_req_ready_i = 1'b0;
		dram_rsp_valid_i = 1'b0;
		dram_rsp_i       = '0;
		wait_cnt         = 0;
		forever begin
			@(negedge Clk_32UI);
			dram_rsp_valid_i = 1'b0;
			if (wait_cnt > 0) begin
				wait_cnt--;
				if (wait_cnt == 0) begin
					dram_rsp_i       = occ_lookup(req_q);
					dram_rsp_valid_i = 1'b1;
				end
			end
			r = $random(mem_seed);
			dram_req_ready_i = (r[1:0] != 2'd0);
			if (rst_n_i && dram_req_valid_o === 1'b1 && dram_req_ready_i) begin
				req_q    = dram_req_o;
				if (req_q.read_num != req_read) begin
					req_read++;  // engine moved on to the next read
				end
				compare_field("dram_req_o.read_num", req_read, req_q.read_num);
				wait_cnt = 1 + int'(r[9:8]);  // 1 to 4 cycles
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge Clk_32UI);
			cycles++;
			if (timeout_limit > 0 && cycles > timeout_limit) begin
				$display("Timeout after %0d cycles, the batches did not complete", cycles);
				$display("TEST FAILED");
				$fatal(1, "cycle limit reached");
			end
		end
	end

	initial begin : main
		int b;
		seed          = SEED;
		mem_seed      = SEED + 1;
		rdy_seed      = SEED + 2;
		n_rows        = 0;
		batch_n       = '{0, 0};
		first_row     = '{0, 0};
		timeout_limit = 0;
		rst_n_i       = 1'b0;
		load_valid_i  = 1'b0;
		load_data_i   = '0;
		batch_size_i  = '0;
		out_ready_i   = 1'b0;
		build_table();

		repeat (16) @(posedge Clk_32UI);
		@(negedge Clk_32UI);
		rst_n_i = 1'b1;
		compare_field("load_done_o", 0, load_done_o);
		compare_field("dram_req_valid_o", 0, dram_req_valid_o);
		compare_field("out_valid_o", 0, out_valid_o);
		compare_field("out_finish_o", 0, out_finish_o);

		// second batch starts only after the first has finished
		for (b = 0; b < 2; b++) begin
			load_batch(b);
			collect_batch(b);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/smem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module smem_top (
	input  wire                         Clk_32UI,
	input  wire                         rst_n_i,
	input  wire                         load_valid_i,
	input  wire read_pkg::read_line_t   load_data_i,
	input  wire [read_pkg::BATCH_W-1:0] batch_size_i,
	output wire                         load_done_o,
	output wire                         dram_req_valid_o,
	input  wire                         dram_req_ready_i,
	output fmi_pkg::occ_req_t           dram_req_o,
	input  wire                         dram_rsp_valid_i,
	input  wire fmi_pkg::occ_rsp_t      dram_rsp_i,
	output wire                         out_valid_o,
	input  wire                         out_ready_i,
	output read_pkg::result_t           out_data_o,
	output wire                         out_finish_o
);
	import fmi_pkg::*;
	import read_pkg::*;

	// ------------------------------
	// loader to engine
	logic     new_batch;
	idx_hdr_t idx_hdr;
	logic     job_valid;
	logic     job_ready;
	job_t     job;

	// engine to writer
	logic    res_valid;
	logic    res_ready;
	result_t res;

	read_loader u_loader (
		.Clk_32UI     (Clk_32UI),
		.rst_n_i      (rst_n_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.batch_size_i (batch_size_i),
		.load_done_o  (load_done_o),
		.new_batch_o  (new_batch),
		.idx_hdr_o    (idx_hdr),
		.job_valid_o  (job_valid),
		.job_ready_i  (job_ready),
		.job_o        (job)
	);

	extend_engine u_engine (
		.Clk_32UI         (Clk_32UI),
		.rst_n_i          (rst_n_i),
		.idx_hdr_i        (idx_hdr),
		.job_valid_i      (job_valid),
		.job_ready_o      (job_ready),
		.job_i            (job),
		.dram_req_valid_o (dram_req_valid_o),
		.dram_req_ready_i (dram_req_ready_i),
		.dram_req_o       (dram_req_o),
		.dram_rsp_valid_i (dram_rsp_valid_i),
		.dram_rsp_i       (dram_rsp_i),
		.res_valid_o      (res_valid),
		.res_ready_i      (res_ready),
		.res_o            (res)
	);

	result_writer u_writer (
		.Clk_32UI     (Clk_32UI),
		.rst_n_i      (rst_n_i),
		.new_batch_i  (new_batch),  // header clears the finish flag
		.res_valid_i  (res_valid),
		.res_ready_o  (res_ready),
		.res_i        (res),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_data_o   (out_data_o),
		.out_finish_o (out_finish_o)
	);

endmodule

`default_nettype wire

// ==== hdl/result_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_writer (
	input  wire                     Clk_32UI,
	input  wire                     rst_n_i,
	input  wire                     new_batch_i,
	input  wire                     res_valid_i,
	output logic                    res_ready_o,
	input  wire read_pkg::result_t  res_i,
	output logic                    out_valid_o,
	input  wire                     out_ready_i,
	output read_pkg::result_t       out_data_o,
	output logic                    out_finish_o
);
	import read_pkg::*;

	// ------------------------------
	// 4-entry FIFO
	result_t fifo_mem [4];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] count;  // 0..4
	logic push;
	logic pop;

	assign res_ready_o = (count != 3'd4);
	assign out_valid_o = (count != 3'd0);
	assign out_data_o  = fifo_mem[rd_ptr];

	assign push = res_valid_i && res_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			out_finish_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + {2'b00, push} - {2'b00, pop};

			// finish level, up after the last record leaves
			if (pop && out_data_o.last) begin
				out_finish_o <= 1'b1;
			end else if (new_batch_i) begin
				out_finish_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			fifo_mem[wr_ptr] <= res_i;
		end
	end

	// ------------------------------
	// fill level matches the pointer distance
	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		(count <= 3'd4) && (count[1:0] == 2'(wr_ptr - rd_ptr)));

	// a record refused while full must still be offered next cycle
	a_res_held: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		(res_valid_i && !res_ready_o) |=> (res_valid_i && $stable(res_i)));

endmodule

`default_nettype wire

// ==== hdl/extend_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module extend_engine (
	input  wire                    Clk_32UI,
	input  wire                    rst_n_i,
	input  wire fmi_pkg::idx_hdr_t idx_hdr_i,
	input  wire                    job_valid_i,
	output logic                   job_ready_o,
	input  wire read_pkg::job_t    job_i,
	output logic                   dram_req_valid_o,
	input  wire                    dram_req_ready_i,
	output fmi_pkg::occ_req_t      dram_req_o,
	input  wire                    dram_rsp_valid_i,
	input  wire fmi_pkg::occ_rsp_t dram_rsp_i,
	output logic                   res_valid_o,
	input  wire                    res_ready_i,
	output read_pkg::result_t      res_o
);
	import fmi_pkg::*;
	import read_pkg::*;

	ext_state_e state;

	// current read
	job_t job_q;
	logic [LEN_W-1:0] idx_q;  // base being extended, counts down
	logic [LEN_W-1:0] match_len_q;
	logic [IDX_W-1:0] k_q;
	logic [IDX_W-1:0] l_q;

	logic job_take;
	logic rsp_take;
	base_e c;
	logic [IDX_W-1:0] new_k;
	logic [IDX_W-1:0] new_l;
	logic stop;

	// positions past primary shift down by one
	function automatic logic [IDX_W-1:0] adj(
		input logic [IDX_W-1:0] p,
		input logic [IDX_W-1:0] prim
	);
		adj = (p > prim) ? p - 1'b1 : p;
	endfunction

	assign job_take = job_valid_i && job_ready_o;
	assign rsp_take = (state == EX_WAIT) && dram_rsp_valid_i;

	// ------------------------------
	// candidate interval for the current base
	assign c     = job_q.bases[idx_q];
	assign new_k = idx_hdr_i.l2[c] + dram_rsp_i.occ_k[c] + 1'b1;
	assign new_l = idx_hdr_i.l2[c] + dram_rsp_i.occ_l[c] + 1'b1;
	assign stop  = (new_k >= new_l);  // would be empty

	assign job_ready_o      = (state == EX_IDLE);
	assign dram_req_valid_o = (state == EX_REQ);
	assign res_valid_o      = (state == EX_DONE);

	assign dram_req_o = '{
		read_num: job_q.read_num,
		addr_k:   adj(k_q, idx_hdr_i.primary),
		addr_l:   adj(l_q, idx_hdr_i.primary)
	};

	assign res_o = '{
		read_num:  job_q.read_num,
		last:      job_q.last,
		match_len: match_len_q,
		k:         k_q,
		l:         l_q
	};

	// ------------------------------
	// FSM
	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			state <= EX_IDLE;
		end else begin
			case (state)
				EX_IDLE: begin
					if (job_valid_i) begin
						state <= EX_REQ;
					end
				end
				EX_REQ: begin
					if (dram_req_ready_i) begin
						state <= EX_WAIT;
					end
				end
				EX_WAIT: begin
					if (dram_rsp_valid_i) begin
						if (stop || idx_q == '0) begin
							state <= EX_DONE;  // empty or read used up
						end else begin
							state <= EX_REQ;
						end
					end
				end
				EX_DONE: begin
					if (res_ready_i) begin
						state <= EX_IDLE;
					end
				end
				default: begin
					state <= EX_IDLE;
				end
			endcase
		end
	end

	// interval and read registers
	always_ff @(posedge Clk_32UI) begin
		if (job_take) begin
			job_q       <= job_i;
			idx_q       <= job_i.len - 1'b1;  // start from the last base
			match_len_q <= '0;
			k_q         <= '0;
			l_q         <= idx_hdr_i.seq_len + 1'b1;
		end else if (rsp_take && !stop) begin
			k_q         <= new_k;
			l_q         <= new_l;
			match_len_q <= match_len_q + 1'b1;
			idx_q       <= idx_q - 1'b1;
		end
	end

	// single outstanding request, so a response only comes while waiting
	a_rsp_outstanding: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		dram_rsp_valid_i |-> (state == EX_WAIT));

	a_match_len: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		res_valid_o |-> (res_o.match_len <= job_q.len));

endmodule

`default_nettype wire

// ==== hdl/read_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_loader (
	input  wire                         Clk_32UI,
	input  wire                         rst_n_i,
	input  wire                         load_valid_i,
	input  wire read_pkg::read_line_t   load_data_i,
	input  wire [read_pkg::BATCH_W-1:0] batch_size_i,
	output logic                        load_done_o,
	output logic                        new_batch_o,
	output fmi_pkg::idx_hdr_t           idx_hdr_o,
	output logic                        job_valid_o,
	input  wire                         job_ready_i,
	output read_pkg::job_t              job_o
);
	import fmi_pkg::*;
	import read_pkg::*;

	load_state_e state;
	logic [BATCH_W-1:0] cnt;  // lines while loading, jobs while issuing

	// read RAM
	logic [LEN_W-1:0] len_ram [MAX_READS];
	base_e [127:0] base_ram [MAX_READS];

	logic hdr_take;
	logic line_take;
	logic out_free;
	logic job_adv;
	logic last_one;
	logic [READ_NUM_W-1:0] addr;

	assign hdr_take  = (state == LD_HDR) && load_valid_i;
	assign line_take = (state == LD_READS) && load_valid_i;
	assign out_free  = !job_valid_o || job_ready_i;  // job register empty or leaving
	assign job_adv   = (state == LD_ISSUE) && out_free && (cnt != batch_size_i);
	assign last_one  = (cnt == batch_size_i - 1'b1);
	assign addr      = cnt[READ_NUM_W-1:0];

	// ------------------------------
	// control
	always_ff @(posedge Clk_32UI) begin
		if (!rst_n_i) begin
			state       <= LD_HDR;
			cnt         <= '0;
			load_done_o <= 1'b0;
			new_batch_o <= 1'b0;
			job_valid_o <= 1'b0;
		end else begin
			new_batch_o <= hdr_take;
			case (state)
				LD_HDR: begin
					if (load_valid_i) begin
						load_done_o <= 1'b0;  // done stays up until the next header
						cnt         <= '0;
						state       <= LD_READS;
					end
				end
				LD_READS: begin
					if (load_valid_i) begin
						if (last_one) begin
							cnt         <= '0;
							load_done_o <= 1'b1;
							state       <= LD_ISSUE;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				LD_ISSUE: begin
					if (job_adv) begin
						job_valid_o <= 1'b1;
						cnt         <= cnt + 1'b1;
					end else if (out_free) begin
						// last job gone
						job_valid_o <= 1'b0;
						state       <= LD_HDR;
					end
				end
				default: begin
					state <= LD_HDR;
				end
			endcase
		end
	end

	// ------------------------------
	// header, RAM and job register
	always_ff @(posedge Clk_32UI) begin
		if (hdr_take) begin
			idx_hdr_o <= idx_hdr_t'(load_data_i[$bits(idx_hdr_t)-1:0]);
		end
		if (line_take) begin
			len_ram[addr]  <= load_data_i.len;
			base_ram[addr] <= load_data_i.bases;
		end
		if (job_adv) begin
			// RAM read lands straight in the job register
			job_o.read_num <= addr;
			job_o.last     <= last_one;
			job_o.len      <= len_ram[addr];
			job_o.bases    <= base_ram[addr];
		end
	end

	// the RAM is read while issuing, so the input side must be quiet
	a_no_load_while_issue: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		(state == LD_ISSUE) |-> !load_valid_i);

	a_read_len: assert property (@(posedge Clk_32UI) disable iff (!rst_n_i)
		line_take |-> (load_data_i.len != '0) && (load_data_i.len <= MAX_LEN));

endmodule

`default_nettype wire

// ==== hdl/read_pkg.sv ====
`default_nettype none

package read_pkg;

	localparam int CL_W       = 512;  // load line
	localparam int MAX_READS  = 64;
	localparam int READ_NUM_W = 6;
	localparam int BATCH_W    = 7;    // holds 1..64
	localparam int MAX_LEN    = 101;
	localparam int LEN_W      = 7;

	// ------------------------------
	// one read per load line, base i at bits 2i+1:2i
	typedef struct packed {
		logic [CL_W-LEN_W-256-1:0] pad;
		logic [LEN_W-1:0]          len;
		fmi_pkg::base_e [127:0]    bases;
	} read_line_t;

	// loader to engine
	typedef struct packed {
		logic [READ_NUM_W-1:0]  read_num;
		logic                   last;   // final read of the batch
		logic [LEN_W-1:0]       len;
		fmi_pkg::base_e [127:0] bases;
	} job_t;

	// engine to writer and out
	typedef struct packed {
		logic [READ_NUM_W-1:0]     read_num;
		logic                      last;
		logic [LEN_W-1:0]          match_len;
		logic [fmi_pkg::IDX_W-1:0] k;
		logic [fmi_pkg::IDX_W-1:0] l;
	} result_t;

	// ------------------------------
	typedef enum logic [1:0] {
		LD_HDR,
		LD_READS,
		LD_ISSUE
	} load_state_e;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_REQ,
		EX_WAIT,
		EX_DONE
	} ext_state_e;

endpackage

`default_nettype wire

// ==== hdl/fmi_pkg.sv ====
`default_nettype none

package fmi_pkg;

	// positions and counts in the index
	localparam int IDX_W = 64;

	// 2-bit base code, also the index into l2 and occ arrays
	typedef enum logic [1:0] {
		BASE_A = 2'd0,
		BASE_C = 2'd1,
		BASE_G = 2'd2,
		BASE_T = 2'd3
	} base_e;

	// ------------------------------
	// index header, sits in the low 384 bits of the first line
	typedef struct packed {
		logic [IDX_W-1:0]      seq_len;
		logic [3:0][IDX_W-1:0] l2;       // cumulative base counts, [0] = A
		logic [IDX_W-1:0]      primary;  // lsb of the line
	} idx_hdr_t;

	// ------------------------------
	// occurrence lookup, addresses already adjusted for primary
	typedef struct packed {
		logic [5:0]       read_num;  // tag, read number width
		logic [IDX_W-1:0] addr_k;
		logic [IDX_W-1:0] addr_l;
	} occ_req_t;

	// one count per base for each bound
	typedef struct packed {
		logic [3:0][IDX_W-1:0] occ_k;
		logic [3:0][IDX_W-1:0] occ_l;
	} occ_rsp_t;

endpackage

`default_nettype wire
